//--- spectrum_meter.f
hdl/spec_pkg.sv
hdl/bin_framer.sv
hdl/bin_fifo.sv
hdl/mag_loudness.sv
hdl/spectrum_meter.sv
tb/spectrum_meter_assert.sv
tb/spectrum_meter_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compiles and runs the meter testbench with Verilator
# Exit status is 0 only when the simulation prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module spectrum_meter_tb -f spectrum_meter.f -Mdir obj_dir \
    || { echo "Build failed"; exit 1; }

out=$(./obj_dir/Vspectrum_meter_tb 2>&1)
echo "$out"
echo "$out" | grep -q "^Result: PASSED$" && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }

//--- tb/spectrum_meter_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Table-driven testbench for the spectral loudness meter
// Each row is one run of bins with a sync on its first bin
module spectrum_meter_tb import spec_pkg::*; ();

    localparam int          CLK_PERIOD = 20;
    localparam logic [31:0] SEED       = 32'h1a21_1ea2;

    // Value patterns
    localparam int PAT_RAMP = 0;
    localparam int PAT_EXT  = 1;   // Both parts at the most negative value
    localparam int PAT_RAND = 2;

    typedef struct packed {
        int   len;   // Bins driven in the row
        int   gap;   // Idle cycles after each bin
        int   pat;
        logic ovf;   // Overflow expected after the row
    } row_t;

    localparam int   N_ROWS = 7;
    localparam row_t ROWS [N_ROWS] = '{
        '{N_BINS, 2, PAT_RAMP, 1'b0},   // Spaced full frame
        '{N_BINS, 3, PAT_EXT,  1'b0},   // 2 * 2^30 per bin
        '{N_BINS, 2, PAT_RAND, 1'b0},
        '{7,      2, PAT_RAND, 1'b0},   // Cut short by the next sync
        '{N_BINS, 2, PAT_RAMP, 1'b0},   // Loudness of this frame only
        '{N_BINS, 0, PAT_RAND, 1'b0},   // Burst the buffer absorbs
        '{96,     0, PAT_RAND, 1'b1}    // Burst past depth plus drain
    };

    logic                       clk;
    logic                       reset;
    logic                       bin_valid;
    logic                       frame_sync;
    logic signed [SAMPLE_W-1:0] bin_real;
    logic signed [SAMPLE_W-1:0] bin_imag;
    logic [MAG_W-1:0]           mag_sq;
    logic                       mag_valid;
    logic [LOUD_W-1:0]          loudness;
    logic                       loudness_valid;
    logic                       overflow;

    // Reference model queues
    logic [MAG_W-1:0]  exp_mag  [$];
    logic [LOUD_W-1:0] exp_loud [$];
    logic              track;   // Low once bins may be dropped

    spectrum_meter i_dut (
        .clk            (clk),
        .reset          (reset),
        .bin_valid      (bin_valid),
        .frame_sync     (frame_sync),
        .bin_real       (bin_real),
        .bin_imag       (bin_imag),
        .mag_sq         (mag_sq),
        .mag_valid      (mag_valid),
        .loudness       (loudness),
        .loudness_valid (loudness_valid),
        .overflow       (overflow)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_mag(input logic [MAG_W-1:0] actual,
                             input logic [MAG_W-1:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: mag_sq = %0d, expected %0d", $time, actual, expected);
            fail_run("Magnitude mismatch");
        end
    endtask

    task automatic check_loud(input logic [LOUD_W-1:0] actual,
                              input logic [LOUD_W-1:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: loudness = %0d, expected %0d", $time, actual, expected);
            fail_run("Loudness mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s = %0b, expected %0b", $time, name, actual, expected);
            fail_run("Flag mismatch");
        end
    endtask

    // Part 0 picks the real part and part 1 the imaginary part
    function automatic logic signed [SAMPLE_W-1:0] pick_value(input int pat, input int k,
                                                              input int part);
        case (pat)
            PAT_RAMP: return SAMPLE_W'((k + 1) * ((part != 0) ? -517 : 1021));
            PAT_EXT:  return SAMPLE_W'(-32768);
            default:  return SAMPLE_W'($urandom());
        endcase
    endfunction

    // re^2 + im^2 in 64 bits and cut to the output width
    function automatic logic [MAG_W-1:0] square_sum(input logic signed [SAMPLE_W-1:0] re,
                                                    input logic signed [SAMPLE_W-1:0] im);
        longint m;
        m = longint'(re) * longint'(re) + longint'(im) * longint'(im);
        return MAG_W'(m);
    endfunction

    // Drives one row and fills the reference queues
    task automatic drive_row(input row_t r);
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
        logic [MAG_W-1:0]           mag;
        logic [LOUD_W-1:0]          sum;
        sum = '0;
        for (int k = 0; k < r.len; k++) begin
            re  = pick_value(r.pat, k, 0);
            im  = pick_value(r.pat, k, 1);
            mag = square_sum(re, im);
            if (k % N_BINS == 0)
                sum = LOUD_W'(mag);           // Frame restarts
            else
                sum = sum + LOUD_W'(mag);
            if (track) begin
                exp_mag.push_back(mag);
                if (k % N_BINS == N_BINS - 1)
                    exp_loud.push_back(sum);  // Only complete frames report
            end
            @(posedge clk);
            bin_valid  <= 1'b1;
            frame_sync <= (k == 0);
            bin_real   <= re;
            bin_imag   <= im;
            repeat (r.gap) begin
                @(posedge clk);
                bin_valid  <= 1'b0;
                frame_sync <= 1'b0;
            end
        end
        @(posedge clk);
        bin_valid  <= 1'b0;
        frame_sync <= 1'b0;
    endtask

    // Output monitor samples mid-cycle where registered outputs are stable
    always @(negedge clk) begin
        if (!reset && track) begin
            if (mag_valid) begin
                if (exp_mag.size() == 0)
                    fail_run("A magnitude came out while none was expected");
                else
                    check_mag(mag_sq, exp_mag.pop_front());
            end
            if (loudness_valid) begin
                if (exp_loud.size() == 0)
                    fail_run("A loudness came out while none was expected");
                else
                    check_loud(loudness, exp_loud.pop_front());
            end
        end
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        limit = 200;
        for (int i = 0; i < N_ROWS; i++)
            limit += ROWS[i].len * 4;
        repeat (limit) @(posedge clk);
        fail_run($sformatf("Timeout after %0d cycles, results stopped coming", limit));
    end

    initial begin
        void'($urandom(SEED));
        reset      = 1'b1;
        bin_valid  = 1'b0;
        frame_sync = 1'b0;
        bin_real   = '0;
        bin_imag   = '0;
        track      = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            if (ROWS[i].ovf)
                track = 1'b0;                 // Bins get dropped in this row
            drive_row(ROWS[i]);
            if (ROWS[i].ovf) begin
                repeat (4) @(negedge clk);    // Last write reaches the buffer
            end else begin
                while (exp_mag.size() != 0)
                    @(negedge clk);
            end
            check_flag("overflow", overflow, ROWS[i].ovf);
        end
        repeat (60) @(negedge clk);           // Sticky flag while the buffer drains
        check_flag("overflow", overflow, ROWS[N_ROWS-1].ovf);
        if (exp_loud.size() != 0) begin
            fail_run("Some expected loudness values never came out");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/spectrum_meter_assert.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the meter's internal handshake and its outputs
module spectrum_meter_assert (
    input wire logic clk,
    input wire logic reset,
    input wire logic rd_en,           // Consumer pop
    input wire logic empty,           // Buffer state
    input wire logic mag_valid,
    input wire logic loudness_valid,
    input wire logic overflow
);

    // Consumer never pops an empty buffer
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty)
        else $error("rd_en high while the buffer is empty");

    // Shared multiplier, at most one bin every two cycles
    a_mag_spacing: assert property (@(posedge clk) disable iff (reset)
        mag_valid |=> !mag_valid)
        else $error("mag_valid high in two consecutive cycles");

    // Loudness only with the last bin's magnitude
    a_loud_with_mag: assert property (@(posedge clk) disable iff (reset)
        loudness_valid |-> mag_valid)
        else $error("loudness_valid without mag_valid");

    a_overflow_sticky: assert property (@(posedge clk) disable iff (reset)
        overflow |=> overflow)
        else $error("overflow fell without a reset");

endmodule

bind spectrum_meter spectrum_meter_assert i_assert (
    .clk            (clk),
    .reset          (reset),
    .rd_en          (rd_en),
    .empty          (empty),
    .mag_valid      (mag_valid),
    .loudness_valid (loudness_valid),
    .overflow       (overflow)
);

`default_nettype wire

//--- hdl/spectrum_meter.sv
`timescale 1ns/1ps
`default_nettype none

// Spectral loudness meter behind an FFT core
// Framer tags bins, buffer absorbs bursts, consumer squares and sums
module spectrum_meter import spec_pkg::*; (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       bin_valid,      // Bin strobe from the FFT
    input  wire logic                       frame_sync,     // Restarts the frame count
    input  wire logic signed [SAMPLE_W-1:0] bin_real,
    input  wire logic signed [SAMPLE_W-1:0] bin_imag,
    output logic [MAG_W-1:0]                mag_sq,
    output logic                            mag_valid,
    output logic [LOUD_W-1:0]               loudness,
    output logic                            loudness_valid,
    output logic                            overflow        // Sticky, a bin was lost
);

    // Framer to buffer
    logic                       wr_en;
    logic signed [SAMPLE_W-1:0] wr_real;
    logic signed [SAMPLE_W-1:0] wr_imag;
    logic                       wr_first;
    logic                       wr_last;

    // Buffer to consumer, show-ahead
    logic                       rd_en;
    logic signed [SAMPLE_W-1:0] rd_real;
    logic signed [SAMPLE_W-1:0] rd_imag;
    logic                       rd_first;
    logic                       rd_last;
    logic                       empty;

    bin_framer i_framer (
        .clk        (clk),
        .reset      (reset),
        .bin_valid  (bin_valid),
        .frame_sync (frame_sync),
        .bin_real   (bin_real),
        .bin_imag   (bin_imag),
        .wr_en      (wr_en),
        .wr_real    (wr_real),
        .wr_imag    (wr_imag),
        .wr_first   (wr_first),
        .wr_last    (wr_last)
    );

    bin_fifo i_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_real  (wr_real),
        .wr_imag  (wr_imag),
        .wr_first (wr_first),
        .wr_last  (wr_last),
        .rd_en    (rd_en),
        .rd_real  (rd_real),
        .rd_imag  (rd_imag),
        .rd_first (rd_first),
        .rd_last  (rd_last),
        .empty    (empty),
        .overflow (overflow)
    );

    mag_loudness i_mag (
        .clk            (clk),
        .reset          (reset),
        .empty          (empty),
        .rd_real        (rd_real),
        .rd_imag        (rd_imag),
        .rd_first       (rd_first),
        .rd_last        (rd_last),
        .rd_en          (rd_en),
        .mag_sq         (mag_sq),
        .mag_valid      (mag_valid),
        .loudness       (loudness),
        .loudness_valid (loudness_valid)
    );

endmodule

`default_nettype wire

//--- hdl/mag_loudness.sv
`timescale 1ns/1ps
`default_nettype none

// Magnitude squared per bin and loudness per frame
// One signed multiplier serves both squares, so a bin takes two cycles:
//   P   pop, real part squared into re_sq
//   P+1 imag part squared, sum and accumulate into output registers
//   P+2 mag_valid, next pop allowed
module mag_loudness import spec_pkg::*; (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       empty,
    input  wire logic signed [SAMPLE_W-1:0] rd_real,
    input  wire logic signed [SAMPLE_W-1:0] rd_imag,
    input  wire logic                       rd_first,
    input  wire logic                       rd_last,
    output logic                            rd_en,          // Pop strobe to the buffer
    output logic [MAG_W-1:0]                mag_sq,
    output logic                            mag_valid,
    output logic [LOUD_W-1:0]               loudness,
    output logic                            loudness_valid  // Only for complete frames
);

    logic                         phase;      // High in the second cycle of a bin
    logic signed [SAMPLE_W-1:0]   im_hold;    // Imag part waiting for the multiplier
    logic                         first_hold;
    logic                         last_hold;
    logic [2*SAMPLE_W-1:0]        re_sq;      // Real part squared, never negative

    logic signed [SAMPLE_W-1:0]   mul_op;
    logic signed [2*SAMPLE_W-1:0] mul_prod;
    logic [MAG_W-1:0]             mag_next;

    logic [LOUD_W-1:0]            acc;        // Running sum of the current frame
    logic [LOUD_W-1:0]            acc_next;

    // Pop only in the first phase, so the bin before is done multiplying
    assign rd_en = !phase && !empty;

    // Shared multiplier, operand picked by phase
    assign mul_op   = phase ? im_hold : rd_real;
    assign mul_prod = mul_op * mul_op;        // (-32768)^2 = 2^30 still fits

    // Both squares are non-negative, so zero extension is exact
    assign mag_next = {1'b0, re_sq} + {1'b0, mul_prod};

    // A first bin restarts the sum, dropping any frame cut short by a sync
    assign acc_next = first_hold ? LOUD_W'(mag_next)
                                 : acc + LOUD_W'(mag_next);

    // Two-phase controller and output strobes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase          <= 1'b0;
            mag_valid      <= 1'b0;
            loudness_valid <= 1'b0;
        end else begin
            phase          <= rd_en;               // Second phase follows each pop
            mag_valid      <= phase;               // Lands in P+2
            loudness_valid <= phase && last_hold;  // Same cycle as the last bin's mag_valid
        end
    end

    // First phase, capture the popped bin
    always_ff @(posedge clk) begin
        if (rd_en) begin
            re_sq      <= mul_prod;
            im_hold    <= rd_imag;
            first_hold <= rd_first;
            last_hold  <= rd_last;
        end
    end

    // Second phase, sum the squares and update the frame total
    always_ff @(posedge clk) begin
        if (phase) begin
            mag_sq <= mag_next;
            acc    <= acc_next;
            if (last_hold)
                loudness <= acc_next;              // Total includes the last bin
        end
    end

endmodule

`default_nettype wire

//--- hdl/bin_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// Show-ahead buffer for tagged bins
// Absorbs FFT bursts, the consumer drains at most one bin per two cycles
module bin_fifo import spec_pkg::*; (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       wr_en,
    input  wire logic signed [SAMPLE_W-1:0] wr_real,
    input  wire logic signed [SAMPLE_W-1:0] wr_imag,
    input  wire logic                       wr_first,
    input  wire logic                       wr_last,
    input  wire logic                       rd_en,      // Pops the entry on show
    output logic signed [SAMPLE_W-1:0]      rd_real,    // Oldest entry
    output logic signed [SAMPLE_W-1:0]      rd_imag,
    output logic                            rd_first,
    output logic                            rd_last,
    output logic                            empty,
    output logic                            overflow    // Sticky, cleared by reset only
);

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;      // Occupancy, 0 to FIFO_DEPTH
    logic               full;
    logic               do_write;
    logic               do_read;

    assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // A write into a full buffer is lost, even with a pop in the same cycle
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // Head entry is always on the read port
    assign {rd_real, rd_imag, rd_first, rd_last} = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= {wr_real, wr_imag, wr_first, wr_last};
    end

    // Pointers, occupancy and overflow flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two, wraps by itself
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
            if (wr_en && full)
                overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bin_framer.sv
`timescale 1ns/1ps
`default_nettype none

// Counts bins within a frame and tags the first and last one
module bin_framer import spec_pkg::*; (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       bin_valid,   // One strobe per FFT bin
    input  wire logic                       frame_sync,  // Bin in this cycle is bin 0
    input  wire logic signed [SAMPLE_W-1:0] bin_real,
    input  wire logic signed [SAMPLE_W-1:0] bin_imag,
    output logic                            wr_en,       // Registered write strobe
    output logic signed [SAMPLE_W-1:0]      wr_real,
    output logic signed [SAMPLE_W-1:0]      wr_imag,
    output logic                            wr_first,    // Bin index 0
    output logic                            wr_last      // Bin index N_BINS-1
);

    localparam logic [BIN_IDX_W-1:0] LAST_IDX = BIN_IDX_W'(N_BINS - 1);

    logic [BIN_IDX_W-1:0] idx;       // Index of the next bin
    logic [BIN_IDX_W-1:0] cur_idx;   // Index of the bin in this cycle
    logic                 synced;    // First sync seen
    logic                 fwd;       // This bin goes to the buffer

    // Sync overrides the running count
    assign cur_idx = frame_sync ? '0 : idx;

    // Nothing is forwarded until the frame grid is known
    assign fwd = bin_valid && (frame_sync || synced);

    // Control state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idx    <= '0;
            synced <= 1'b0;
            wr_en  <= 1'b0;
        end else begin
            wr_en <= fwd;                          // One cycle behind bin_valid
            if (frame_sync)
                synced <= 1'b1;
            if (fwd) begin
                // Wrap after the last bin of a frame
                if (cur_idx == LAST_IDX)
                    idx <= '0;
                else
                    idx <= cur_idx + 1'b1;
            end else if (frame_sync) begin
                idx <= '0;                         // Sync without a bin, next bin is 0
            end
        end
    end

    // Payload and tags, qualified by wr_en
    always_ff @(posedge clk) begin
        if (fwd) begin
            wr_real  <= bin_real;
            wr_imag  <= bin_imag;
            wr_first <= (cur_idx == '0);
            wr_last  <= (cur_idx == LAST_IDX);
        end
    end

endmodule

`default_nettype wire

//--- hdl/spec_pkg.sv
`default_nettype none

// Shared sizes for the spectral loudness meter
package spec_pkg;

    // FFT bin samples, real and imaginary parts are signed
    localparam int SAMPLE_W   = 16;

    // Bins per frame, small for simulation
    localparam int N_BINS     = 16;
    localparam int BIN_IDX_W  = $clog2(N_BINS);    // Bin counter width

    // Magnitude squared carries one spare bit for re^2 + im^2
    localparam int MAG_W      = 2 * SAMPLE_W + 1;

    // Loudness grows by log2(N_BINS) over a full frame
    localparam int LOUD_W     = MAG_W + BIN_IDX_W;

    // Burst buffer between framer and consumer
    localparam int FIFO_DEPTH = 32;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // Entry layout is {real, imag, first, last}
    localparam int ENTRY_W    = 2 * SAMPLE_W + 2;

endpackage

`default_nettype wire
